// File: all.f
hdl/qla_pkg.sv
hdl/sample_ram.sv
hdl/axil_reg_bridge.sv
hdl/motor_reg_file.sv
hdl/feedback_select.sv
hdl/data_buffer.sv
hdl/qla_collect_top.sv
sim/tb_clk_gen.sv
sim/tb_qla_collect.sv

// File: hdl/axil_reg_bridge.sv
`timescale 1ns/100ps

module axil_reg_bridge import qla_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   // axi4-lite write channels
   input  logic [reg_aw-1:0] s_awaddr,
   input  logic              s_awvalid,
   output logic              s_awready,
   input  logic [data_w-1:0] s_wdata,
   input  logic              s_wvalid,
   output logic              s_wready,
   output logic [1:0]        s_bresp,
   output logic              s_bvalid,
   input  logic              s_bready,
   // axi4-lite read channels
   input  logic [reg_aw-1:0] s_araddr,
   input  logic              s_arvalid,
   output logic              s_arready,
   output logic [data_w-1:0] s_rdata,
   output logic [1:0]        s_rresp,
   output logic              s_rvalid,
   input  logic              s_rready,
   // register bus
   output logic [reg_aw-1:0] reg_waddr,
   output logic [data_w-1:0] reg_wdata,
   output logic              reg_wen,
   output logic [reg_aw-1:0] reg_raddr,
   input  logic [data_w-1:0] main_rdata,
   input  logic [data_w-1:0] buf_rdata
);

   logic       wr_acc;        // write address and data taken together
   logic       rd_acc;        // read address taken
   logic       rd_busy;       // read in flight or response pending
   logic       rd_stage;      // registered address valid, ram reading
   logic       rd_load;       // ram data valid, capture into s_rdata
   logic [3:0] rd_space;      // space nibble, delayed to match ram
   logic [data_w-1:0] rd_mux; // selected read data

   assign wr_acc = s_awvalid && s_wvalid && s_awready && s_wready;
   assign rd_acc = s_arvalid && s_arready;

   assign s_bresp = resp_okay;   // never an error
   assign s_rresp = resp_okay;

   // register bus write side, strobe in the accept cycle
   assign reg_wen = wr_acc;
   assign reg_waddr = s_awaddr;
   assign reg_wdata = s_wdata;

   // ----------------------------------------
   // write handshake
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s_awready <= 1'b0;
         s_wready <= 1'b0;
         s_bvalid <= 1'b0;
      end else if (wr_acc) begin
         s_awready <= 1'b0;             // hold off until response taken
         s_wready <= 1'b0;
         s_bvalid <= 1'b1;              // response next cycle
      end else if (s_bvalid && s_bready) begin
         s_bvalid <= 1'b0;
         s_awready <= 1'b1;             // ready again
         s_wready <= 1'b1;
      end else if (!s_bvalid) begin
         s_awready <= 1'b1;             // idle, first cycle after reset
         s_wready <= 1'b1;
      end
   end

   // ----------------------------------------
   // read handshake and pipeline
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s_arready <= 1'b0;
         rd_busy <= 1'b0;
         rd_stage <= 1'b0;
         rd_load <= 1'b0;
         s_rvalid <= 1'b0;
         reg_raddr <= '0;
         rd_space <= '0;
      end else begin
         rd_stage <= rd_acc;           // address registered this edge
         rd_load <= rd_stage;          // ram output valid next cycle
         if (rd_acc) begin
            s_arready <= 1'b0;
            rd_busy <= 1'b1;
            reg_raddr <= s_araddr;     // held until next accept
         end else if (s_rvalid && s_rready) begin
            s_rvalid <= 1'b0;
            rd_busy <= 1'b0;
            s_arready <= 1'b1;
         end else if (!rd_busy) begin
            s_arready <= 1'b1;         // idle
         end
         if (rd_stage) begin
            rd_space <= reg_raddr[space_lsb +: 4];   // lines up with ram data
         end
         if (rd_load) begin
            s_rvalid <= 1'b1;          // two edges after accept
         end
      end
   end

   // data mux by space nibble
   always_comb begin
      case (rd_space)
         addr_main: rd_mux = main_rdata;
         addr_buf:  rd_mux = buf_rdata;
         default:   rd_mux = '0;        // unmapped space reads zero
      endcase
   end

   // read data held stable until s_rready
   always_ff @(posedge clk) begin
      if (rd_load) begin
         s_rdata <= rd_mux;
      end
   end

endmodule

// File: hdl/data_buffer.sv
`timescale 1ns/100ps

module data_buffer import qla_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   // feedback side
   input  logic              cur_fb_wen,   // ready level from selector
   input  logic [cur_w-1:0]  cur_fb,
   output logic [chan_w-1:0] chan,         // channel under collection
   // register bus
   input  logic [reg_aw-1:0] reg_waddr,
   input  logic [data_w-1:0] reg_wdata,
   input  logic              reg_wen,
   input  logic [reg_aw-1:0] reg_raddr,
   output logic [data_w-1:0] buf_rdata
);

   logic              collecting;    // collection running
   logic              buf_wr;        // ram write strobe
   logic [buf_aw-1:0] buf_wr_addr;   // current write address
   logic [data_w-1:0] buf_wr_data;   // formatted entry
   logic              fb_wen_last;   // edge detect on cur_fb_wen
   logic              fb_edge;
   logic              cmd_hit;       // commanded current write, main space
   logic              cmd_wen;       // write that affects collection
   logic              collect_req;   // collect bit of the write
   logic [chan_w-1:0] wr_ch;
   logic [data_w-1:0] mem_rd;

   assign wr_ch = reg_waddr[chan_lsb +: chan_w];
   assign collect_req = reg_wdata[collect_bit];
   assign fb_edge = cur_fb_wen && !fb_wen_last;

   assign cmd_hit = reg_wen && (reg_waddr[space_lsb +: 4] == addr_main) &&
                    (reg_waddr[3:0] == off_cmd_cur);
   // start when idle, or any write to the collected channel
   assign cmd_wen = cmd_hit && ((!collecting && collect_req) ||
                                (collecting && (wr_ch == chan)));

   // ----------------------------------------
   // collection control and addressing
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         chan <= chan_w'(1);
         collecting <= 1'b0;
         buf_wr <= 1'b0;
         buf_wr_addr <= '0;
         fb_wen_last <= 1'b0;
      end else begin
         buf_wr <= 1'b0;
         fb_wen_last <= cur_fb_wen;
         if (cmd_wen) begin                    // commanded write wins
            if (collect_req) begin
               buf_wr <= 1'b1;
               if (!collecting) begin
                  chan <= wr_ch;               // latch channel on start
                  buf_wr_addr <= '0;           // entry 0
               end else begin
                  buf_wr_addr <= buf_wr_addr + 1'b1;
               end
            end
            collecting <= collect_req;         // bit clear stops, no entry
         end else if (collecting && fb_edge) begin
            buf_wr <= 1'b1;
            buf_wr_addr <= buf_wr_addr + 1'b1;
         end
      end
   end

   // entry formatting
   always_ff @(posedge clk) begin
      if (cmd_wen) begin
         buf_wr_data <= {flag_cmd, {buf_aw{1'b0}}, wr_ch, reg_wdata[cur_w-1:0]};
      end else if (fb_edge) begin
         buf_wr_data <= {flag_fb, {buf_aw{1'b0}}, chan, cur_fb};
      end
   end

   sample_ram i_sample_ram (
      .clk   (clk),
      .we    (buf_wr),
      .waddr (buf_wr_addr),
      .wdata (buf_wr_data),
      .raddr (reg_raddr[buf_aw-1:0]),
      .rdata (mem_rd)
   );

   // readback shows the fill level in place of the zero field
   assign buf_rdata = {mem_rd[data_w-1 -: flag_w], buf_wr_addr,
                       mem_rd[chan_w+cur_w-1:0]};

endmodule

// File: hdl/feedback_select.sv
`timescale 1ns/100ps

module feedback_select import qla_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [chan_w-1:0] chan,         // channel under collection
   input  logic              adc_valid,    // one strobe per conversion round
   input  logic [cur_w-1:0]  adc_data_1,
   input  logic [cur_w-1:0]  adc_data_2,
   input  logic [cur_w-1:0]  adc_data_3,
   input  logic [cur_w-1:0]  adc_data_4,
   output logic [cur_w-1:0]  cur_fb,       // latched sample
   output logic              cur_fb_wen    // two-cycle ready level
);

   logic [cur_w-1:0] sel_data;   // sample of the selected channel
   logic             sel_ok;     // channel inside 1..4
   logic [1:0]       stretch;    // cycles left of cur_fb_wen

   always_comb begin
      sel_ok = 1'b1;
      case (chan)
         chan_w'(1): sel_data = adc_data_1;
         chan_w'(2): sel_data = adc_data_2;
         chan_w'(3): sel_data = adc_data_3;
         chan_w'(4): sel_data = adc_data_4;
         default: begin
            sel_data = '0;
            sel_ok = 1'b0;     // no strobe for bad channel
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (adc_valid && sel_ok) begin
         cur_fb <= sel_data;
      end
   end

   // valid stretch, reloads on every accepted round
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stretch <= 2'd0;
      end else if (adc_valid && sel_ok) begin
         stretch <= 2'd2;
      end else if (stretch != 2'd0) begin
         stretch <= stretch - 2'd1;
      end
   end

   assign cur_fb_wen = (stretch != 2'd0);

endmodule

// File: hdl/motor_reg_file.sv
`timescale 1ns/100ps

module motor_reg_file import qla_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [reg_aw-1:0] reg_waddr,
   input  logic [data_w-1:0] reg_wdata,
   input  logic              reg_wen,
   input  logic [reg_aw-1:0] reg_raddr,
   output logic [data_w-1:0] main_rdata   // registered, same latency as ram
);

   logic [cur_w-1:0] cmd_cur [num_chan];  // commanded current per channel
   logic             wr_hit;              // commanded current write, main space
   logic             rd_hit;              // commanded current read, main space
   logic [chan_w-1:0] wr_ch;
   logic [chan_w-1:0] rd_ch;
   logic [data_w-1:0] rd_val;

   assign wr_ch = reg_waddr[chan_lsb +: chan_w];
   assign rd_ch = reg_raddr[chan_lsb +: chan_w];

   assign wr_hit = reg_wen && (reg_waddr[space_lsb +: 4] == addr_main) &&
                   (reg_waddr[3:0] == off_cmd_cur);
   assign rd_hit = (reg_raddr[space_lsb +: 4] == addr_main) &&
                   (reg_raddr[3:0] == off_cmd_cur);

   // ----------------------------------------
   // channel registers
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_chan; i++) begin
            cmd_cur[i] <= '0;
         end
      end else if (wr_hit) begin
         for (int i = 0; i < num_chan; i++) begin
            if (wr_ch == chan_w'(i + 1)) begin
               cmd_cur[i] <= reg_wdata[cur_w-1:0];   // low half only
            end
         end
      end
   end

   // read select, channel 0 and 5..15 fall through to zero
   always_comb begin
      rd_val = '0;
      for (int i = 0; i < num_chan; i++) begin
         if (rd_hit && (rd_ch == chan_w'(i + 1))) begin
            rd_val = {{(data_w - cur_w){1'b0}}, cmd_cur[i]};
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         main_rdata <= '0;
      end else begin
         main_rdata <= rd_val;
      end
   end

endmodule

// File: hdl/qla_collect_top.sv
`timescale 1ns/100ps

module qla_collect_top import qla_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   // axi4-lite slave
   input  logic [reg_aw-1:0] s_awaddr,
   input  logic              s_awvalid,
   output logic              s_awready,
   input  logic [data_w-1:0] s_wdata,
   input  logic              s_wvalid,
   output logic              s_wready,
   output logic [1:0]        s_bresp,
   output logic              s_bvalid,
   input  logic              s_bready,
   input  logic [reg_aw-1:0] s_araddr,
   input  logic              s_arvalid,
   output logic              s_arready,
   output logic [data_w-1:0] s_rdata,
   output logic [1:0]        s_rresp,
   output logic              s_rvalid,
   input  logic              s_rready,
   // adc samples
   input  logic              adc_valid,
   input  logic [cur_w-1:0]  adc_data_1,
   input  logic [cur_w-1:0]  adc_data_2,
   input  logic [cur_w-1:0]  adc_data_3,
   input  logic [cur_w-1:0]  adc_data_4
);

   // register bus
   logic [reg_aw-1:0] reg_waddr;
   logic [data_w-1:0] reg_wdata;
   logic              reg_wen;
   logic [reg_aw-1:0] reg_raddr;
   logic [data_w-1:0] main_rdata;
   logic [data_w-1:0] buf_rdata;

   // feedback path
   logic [chan_w-1:0] chan;
   logic [cur_w-1:0]  cur_fb;
   logic              cur_fb_wen;

   axil_reg_bridge i_axil_reg_bridge (
      .clk        (clk),
      .arst_n     (arst_n),
      .s_awaddr   (s_awaddr),
      .s_awvalid  (s_awvalid),
      .s_awready  (s_awready),
      .s_wdata    (s_wdata),
      .s_wvalid   (s_wvalid),
      .s_wready   (s_wready),
      .s_bresp    (s_bresp),
      .s_bvalid   (s_bvalid),
      .s_bready   (s_bready),
      .s_araddr   (s_araddr),
      .s_arvalid  (s_arvalid),
      .s_arready  (s_arready),
      .s_rdata    (s_rdata),
      .s_rresp    (s_rresp),
      .s_rvalid   (s_rvalid),
      .s_rready   (s_rready),
      .reg_waddr  (reg_waddr),
      .reg_wdata  (reg_wdata),
      .reg_wen    (reg_wen),
      .reg_raddr  (reg_raddr),
      .main_rdata (main_rdata),
      .buf_rdata  (buf_rdata)
   );

   motor_reg_file i_motor_reg_file (
      .clk        (clk),
      .arst_n     (arst_n),
      .reg_waddr  (reg_waddr),
      .reg_wdata  (reg_wdata),
      .reg_wen    (reg_wen),
      .reg_raddr  (reg_raddr),
      .main_rdata (main_rdata)
   );

   feedback_select i_feedback_select (
      .clk        (clk),
      .arst_n     (arst_n),
      .chan       (chan),
      .adc_valid  (adc_valid),
      .adc_data_1 (adc_data_1),
      .adc_data_2 (adc_data_2),
      .adc_data_3 (adc_data_3),
      .adc_data_4 (adc_data_4),
      .cur_fb     (cur_fb),
      .cur_fb_wen (cur_fb_wen)
   );

   data_buffer i_data_buffer (
      .clk        (clk),
      .arst_n     (arst_n),
      .cur_fb_wen (cur_fb_wen),
      .cur_fb     (cur_fb),
      .chan       (chan),
      .reg_waddr  (reg_waddr),
      .reg_wdata  (reg_wdata),
      .reg_wen    (reg_wen),
      .reg_raddr  (reg_raddr),
      .buf_rdata  (buf_rdata)
   );

endmodule

// File: hdl/qla_pkg.sv
package qla_pkg;

   // ----------------------------------------
   // register address map
   // ----------------------------------------
   localparam int reg_aw = 16;                   // register address width
   localparam logic [3:0] addr_main = 4'h0;      // space nibble, main registers
   localparam logic [3:0] addr_buf = 4'h1;       // space nibble, buffer readback
   localparam logic [3:0] off_cmd_cur = 4'h0;    // commanded current offset

   // address field positions
   localparam int space_lsb = 12;                // bits 15:12 hold the space
   localparam int chan_lsb = 4;                  // bits 7:4 hold the channel

   // ----------------------------------------
   // channels and data widths
   // ----------------------------------------
   localparam int num_chan = 4;                  // channels 1 to 4
   localparam int chan_w = 4;                    // channel number width
   localparam int cur_w = 16;                    // motor current width
   localparam int data_w = 32;                   // bus data and buffer word
   localparam int buf_aw = 10;                   // 1024-word buffer

   // ----------------------------------------
   // buffer entry format
   // ----------------------------------------
   // flag(2) | zero / write address(10) | channel(4) | current(16)
   localparam int flag_w = 2;
   localparam logic [flag_w-1:0] flag_cmd = 2'b01;   // commanded current entry
   localparam logic [flag_w-1:0] flag_fb = 2'b11;    // feedback entry

   localparam int collect_bit = 30;              // start/stop bit in cmd write

   // axi response code
   localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: hdl/sample_ram.sv
`timescale 1ns/100ps

module sample_ram import qla_pkg::*; (
   input  logic              clk,
   input  logic              we,      // write strobe
   input  logic [buf_aw-1:0] waddr,   // write word address
   input  logic [data_w-1:0] wdata,   // entry to store
   input  logic [buf_aw-1:0] raddr,   // read word address
   output logic [data_w-1:0] rdata    // registered read data
);

   logic [data_w-1:0] mem [2**buf_aw];   // inferred block ram

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // one cycle read latency
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

// File: run.sh
#!/bin/sh
# compile with verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_qla_collect -f all.f \
   -o tb_qla_collect > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_qla_collect > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1

// File: sim/collect_cases.txt
// op 1 write: addr data 0 | op 2 adc: s1s2 s3s4 0 | op 3 read: addr exp mask
// op 0 ends the list; buffer word = flag(2) waddr(10) chan(4) current(16)
00000001 00000010 00001111 00000000
00000001 00000020 00002222 00000000
00000001 00000030 00003333 00000000
00000001 00000040 00004444 00000000
00000003 00000010 00001111 FFFFFFFF
00000003 00000040 00004444 FFFFFFFF
00000003 00001000 00000000 3FF00000
00000002 0A010A02 0A030A04 00000000
00000003 00001000 00000000 3FF00000
00000001 00000020 40000500 00000000
00000003 00001000 40020500 FFFFFFFF
00000001 00000020 40000501 00000000
00000001 00000030 40000777 00000000
00000001 00000020 40000502 00000000
00000003 00001002 40220502 FFFFFFFF
00000002 0B010B02 0B030B04 00000000
00000003 00001003 C0320B02 FFFFFFFF
00000001 00000020 00000504 00000000
00000002 0C010C02 0C030C04 00000000
00000001 00000020 00000505 00000000
00000003 00001000 40320500 FFFFFFFF
00000003 00000030 00000777 FFFFFFFF
00000003 00000020 00000505 FFFFFFFF
00000000 00000000 00000000 00000000

// File: sim/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;        // 10 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (4) @(posedge clk);    // 4 cycles in reset
      @(negedge clk);
      arst_n = 1'b1;                // release away from the active edge
   end

endmodule

// File: sim/tb_qla_collect.sv
`timescale 1ns/100ps

module tb_qla_collect;

   localparam int max_wait = 50;    // cycles per handshake wait
   localparam int max_ops = 256;    // records in the cases file

   logic        clk;
   logic        arst_n;
   logic [15:0] s_awaddr;
   logic        s_awvalid;
   logic        s_awready;
   logic [31:0] s_wdata;
   logic        s_wvalid;
   logic        s_wready;
   logic [1:0]  s_bresp;
   logic        s_bvalid;
   logic        s_bready;
   logic [15:0] s_araddr;
   logic        s_arvalid;
   logic        s_arready;
   logic [31:0] s_rdata;
   logic [1:0]  s_rresp;
   logic        s_rvalid;
   logic        s_rready;
   logic        adc_valid;
   logic [15:0] adc_data_1;
   logic [15:0] adc_data_2;
   logic [15:0] adc_data_3;
   logic [15:0] adc_data_4;

   logic [31:0] cases_mem [4*max_ops];   // op, arg a, arg b, arg c per record
   logic [31:0] rng_state;
   int          err_cnt;
   int          chk_cnt;
   logic        timed_out;               // a wait ran out of cycles

   tb_clk_gen i_tb_clk_gen (.clk(clk), .arst_n(arst_n));

   qla_collect_top i_qla_collect_top (
      .clk(clk), .arst_n(arst_n),
      .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
      .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
      .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
      .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
      .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
      .adc_valid(adc_valid), .adc_data_1(adc_data_1), .adc_data_2(adc_data_2),
      .adc_data_3(adc_data_3), .adc_data_4(adc_data_4)
   );

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int next_delay();
      rng_state = xorshift(rng_state);
      return int'(rng_state[2:0]);        // 0 to 7 cycles of back-pressure
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // one bounded step of a wait loop
   task automatic tick(inout int n, input string what);
      @(negedge clk);
      n++;
      if (n > max_wait) begin
         timed_out = 1'b1;
         err_cnt++;
         $display("timeout while waiting for %s at %0t", what, $time);
      end
   endtask

   // ----------------------------------------
   // bus and adc operations
   // ----------------------------------------
   task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
      int n;
      int dly;
      @(negedge clk);
      s_awaddr = addr;
      s_wdata = data;
      s_awvalid = 1'b1;
      s_wvalid = 1'b1;
      n = 0;
      while (!(s_awready && s_wready) && !timed_out) tick(n, "write address and data ready");
      if (timed_out) return;
      @(negedge clk);                     // taken on the edge just passed
      s_awvalid = 1'b0;
      s_wvalid = 1'b0;
      dly = next_delay();
      repeat (dly) @(negedge clk);
      n = 0;
      while (!s_bvalid && !timed_out) tick(n, "write response");
      if (timed_out) return;
      check_value("write response code", 32'(s_bresp), 32'h0);
      s_bready = 1'b1;
      @(negedge clk);
      s_bready = 1'b0;
      check_value("write response taken once", 32'(s_bvalid), 32'h0);
   endtask

   task automatic axi_read(input logic [15:0] addr, input logic [31:0] exp,
                           input logic [31:0] mask);
      int n;
      int dly;
      logic [31:0] first;
      @(negedge clk);
      s_araddr = addr;
      s_arvalid = 1'b1;
      n = 0;
      while (!s_arready && !timed_out) tick(n, "read address ready");
      if (timed_out) return;
      @(negedge clk);
      s_arvalid = 1'b0;
      n = 0;
      while (!s_rvalid && !timed_out) tick(n, "read data");
      if (timed_out) return;
      first = s_rdata;
      dly = next_delay();
      repeat (dly) begin                  // data must hold while stalled
         @(negedge clk);
         check_value("read valid held", 32'(s_rvalid), 32'h1);
         check_value("read data held", s_rdata, first);
      end
      check_value("read response code", 32'(s_rresp), 32'h0);
      s_rready = 1'b1;
      @(negedge clk);
      s_rready = 1'b0;
      check_value("read response taken once", 32'(s_rvalid), 32'h0);
      check_value($sformatf("read data at %h", addr), first & mask, exp & mask);
   endtask

   task automatic adc_round(input logic [31:0] s12, input logic [31:0] s34);
      @(negedge clk);
      adc_data_1 = s12[31:16];
      adc_data_2 = s12[15:0];
      adc_data_3 = s34[31:16];
      adc_data_4 = s34[15:0];
      adc_valid = 1'b1;                   // one-cycle strobe
      @(negedge clk);
      adc_valid = 1'b0;
      repeat (3) @(negedge clk);          // edge detect plus ram write
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int n;
      int idx;
      int ops;
      logic [31:0] op;
      s_awaddr = '0;
      s_awvalid = 1'b0;
      s_wdata = '0;
      s_wvalid = 1'b0;
      s_bready = 1'b0;
      s_araddr = '0;
      s_arvalid = 1'b0;
      s_rready = 1'b0;
      adc_valid = 1'b0;
      adc_data_1 = '0;
      adc_data_2 = '0;
      adc_data_3 = '0;
      adc_data_4 = '0;
      err_cnt = 0;
      chk_cnt = 0;
      timed_out = 1'b0;
      ops = 0;
      rng_state = 32'd37;
      $readmemh("sim/collect_cases.txt", cases_mem);
      n = 0;
      while (arst_n !== 1'b1 && !timed_out) tick(n, "reset release");
      for (idx = 0; idx < max_ops && !timed_out; idx++) begin
         op = cases_mem[4*idx];
         if (op === 32'h0) break;         // end record
         ops++;
         case (op)
            32'h1: axi_write(cases_mem[4*idx+1][15:0], cases_mem[4*idx+2]);
            32'h2: adc_round(cases_mem[4*idx+1], cases_mem[4*idx+2]);
            32'h3: axi_read(cases_mem[4*idx+1][15:0], cases_mem[4*idx+2],
                            cases_mem[4*idx+3]);
            default: begin
               err_cnt++;
               $display("unknown operation %h in cases file, record %0d", op, idx);
               break;
            end
         endcase
      end
      if (ops == 0) begin
         err_cnt++;
         $display("no operations were read from the cases file");
      end
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
